//--- data_io.f
+incdir+design
+incdir+tb
design/data_io_pkg.sv
design/spi_shifter.sv
design/byte_sync.sv
design/cmd_decoder.sv
design/data_io_top.sv
tb/tb_data_io.sv

//--- design/byte_sync.sv
`default_nettype none
`timescale 1ns/10ps

module byte_sync
	import data_io_pkg::*;
(
	input  wire logic       sck,
	input  wire logic       ss,
	input  wire logic       rx_toggle,
	input  wire logic       frame_idle,
	input  wire logic [7:0] rx_byte,
	output rx_event_t       rx_ev
);

	// ********************
	// synchronizers
	// ********************

	// two stages each, then one more for edge detection
	logic tog_meta;
	logic tog_sync;
	logic tog_prev;
	logic idle_meta;
	logic idle_sync;
	logic idle_prev;

	logic       byte_seen;
	logic       byte_stb_r;
	logic       frame_end_r;
	logic [7:0] data_r;

	// any change of the toggle is one new byte
	assign byte_seen = tog_sync ^ tog_prev;

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			tog_meta    <= 1'b0;
			tog_sync    <= 1'b0;
			tog_prev    <= 1'b0;
			// serial side sits idle out of reset
			idle_meta   <= 1'b1;
			idle_sync   <= 1'b1;
			idle_prev   <= 1'b1;
			byte_stb_r  <= 1'b0;
			frame_end_r <= 1'b0;
		end else begin
			tog_meta    <= rx_toggle;
			tog_sync    <= tog_meta;
			tog_prev    <= tog_sync;
			idle_meta   <= frame_idle;
			idle_sync   <= idle_meta;
			idle_prev   <= idle_sync;
			byte_stb_r  <= byte_seen;
			// chip select going high ends the frame
			frame_end_r <= idle_sync & ~idle_prev;
		end
	end

	// rx_byte settled long before the toggle got through
	always_ff @(posedge sck) begin
		if (byte_seen) begin
			data_r <= rx_byte;
		end
	end

	// data lines up with its strobe
	assign rx_ev = '{byte_stb: byte_stb_r, frame_end: frame_end_r, data: data_r};

endmodule

`default_nettype wire

//--- design/cmd_decoder.sv
`default_nettype none
`timescale 1ns/10ps

`include "data_io_defines.svh"

module cmd_decoder
	import data_io_pkg::*;
(
	input  wire logic      sck,
	input  wire logic      ss,
	input  wire rx_event_t rx_ev,
	output mem_wr_t        mem_wr,
	output logic           data_out_strobe,
	output logic           data_download,
	output logic [31:0]    ctrl_out,
	output logic [15:0]    video_adj,
	output logic           dma_ack,
	output logic [7:0]     dma_status,
	output logic           dma_nak
);

	// ********************
	// decoder state
	// ********************

	dec_state_e state;
	spi_cmd_e   cmd_r;
	// payload bytes seen so far, saturating
	logic [2:0] pay_cnt;
	// high once the high byte of a word pair is in
	logic       lo;

	// earlier payload bytes, newest in the low byte
	logic [23:0] latch;

	// write path registers
	logic [`DIO_ADDR_W-1:0] addr_r;
	logic [15:0]            wr_data_r;
	logic                   stb_host_r;
	logic                   stb_file_r;

	// a payload byte that the current command may use
	logic pay_byte;

	assign pay_byte = rx_ev.byte_stb && !rx_ev.frame_end && (state == DEC_PAYLOAD);

	assign mem_wr = '{addr: addr_r, data: wr_data_r, stb_host: stb_host_r,
		stb_file: stb_file_r};

	// shift in every payload byte
	// multi-byte settings pick up their upper bytes from here
	always_ff @(posedge sck) begin
		if (pay_byte) begin
			latch <= {latch[15:0], rx_ev.data};
		end
	end

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			state           <= DEC_CMD;
			cmd_r           <= spi_cmd_e'(8'h00);
			pay_cnt         <= 3'd0;
			lo              <= 1'b0;
			addr_r          <= '0;
			wr_data_r       <= 16'h0000;
			stb_host_r      <= 1'b0;
			stb_file_r      <= 1'b0;
			data_out_strobe <= 1'b0;
			data_download   <= 1'b0;
			ctrl_out        <= 32'h0000_0000;
			video_adj       <= 16'h0000;
			dma_ack         <= 1'b0;
			dma_status      <= 8'h00;
			dma_nak         <= 1'b0;
		end else begin
			// pulses last one cycle
			stb_host_r      <= 1'b0;
			stb_file_r      <= 1'b0;
			data_out_strobe <= 1'b0;
			dma_ack         <= 1'b0;
			dma_nak         <= 1'b0;

			if (rx_ev.frame_end) begin
				// next frame starts with an opcode
				state   <= DEC_CMD;
				pay_cnt <= 3'd0;
				lo      <= 1'b0;
			end else if (rx_ev.byte_stb) begin
				case (state)
				// ********************
				// opcode byte
				// ********************
				DEC_CMD: begin
					cmd_r   <= spi_cmd_e'(rx_ev.data);
					pay_cnt <= 3'd0;
					lo      <= 1'b0;
					case (spi_cmd_e'(rx_ev.data))
					CMD_WRITE_MEMORY, CMD_READ_MEMORY, CMD_SET_CONTROL,
					CMD_ACK_DMA, CMD_SET_VADJ, CMD_FILE_TX,
					CMD_FILE_TX_DAT, CMD_FILE_INDEX: begin
						state <= DEC_PAYLOAD;
					end
					CMD_NAK_DMA: begin
						dma_nak <= 1'b1;
						state   <= DEC_IGNORE;
					end
					// status reads and unknown opcodes carry nothing
					default: begin
						state <= DEC_IGNORE;
					end
					endcase
				end

				// ********************
				// payload bytes
				// ********************
				DEC_PAYLOAD: begin
					if (~&pay_cnt) begin
						pay_cnt <= pay_cnt + 3'd1;
					end
					case (cmd_r)
					// four bytes, most significant first
					CMD_SET_CONTROL: begin
						if (pay_cnt == 3'd3) begin
							ctrl_out <= {latch, rx_ev.data};
							state    <= DEC_IGNORE;
						end
					end
					CMD_SET_VADJ: begin
						if (pay_cnt == 3'd1) begin
							video_adj <= {latch[7:0], rx_ev.data};
							state     <= DEC_IGNORE;
						end
					end
					// word pairs, high byte first
					CMD_WRITE_MEMORY, CMD_FILE_TX_DAT: begin
						lo <= ~lo;
						if (lo) begin
							wr_data_r <= {latch[7:0], rx_ev.data};
							if (cmd_r == CMD_FILE_TX_DAT) begin
								// pointer moves with the strobe
								addr_r     <= addr_r + 1'b1;
								stb_file_r <= 1'b1;
							end else begin
								stb_host_r <= 1'b1;
							end
						end
					end
					// memory advances during the low byte
					CMD_READ_MEMORY: begin
						lo <= ~lo;
						if (!lo) begin
							data_out_strobe <= 1'b1;
						end
					end
					CMD_ACK_DMA: begin
						dma_ack    <= 1'b1;
						dma_status <= rx_ev.data;
						state      <= DEC_IGNORE;
					end
					CMD_FILE_TX: begin
						data_download <= |rx_ev.data;
						state         <= DEC_IGNORE;
					end
					// out of range index keeps the pointer
					CMD_FILE_INDEX: begin
						case (rx_ev.data)
						8'h00:   addr_r <= `DIO_IDX0_BASE;
						8'h01:   addr_r <= `DIO_IDX1_BASE;
						8'h02:   addr_r <= `DIO_IDX2_BASE;
						8'h03:   addr_r <= `DIO_IDX3_BASE;
						default: addr_r <= addr_r;
						endcase
						state <= DEC_IGNORE;
					end
					default: begin
						state <= DEC_IGNORE;
					end
					endcase
				end

				// rest of the frame is dropped
				default: begin
					state <= DEC_IGNORE;
				end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- design/data_io_defines.svh
`ifndef DATA_IO_DEFINES_SVH
`define DATA_IO_DEFINES_SVH

// ********************
// memory addressing
// ********************

// word address into the core memory, bit 0 of the byte address dropped
`define DIO_ADDR_W 23

// download index table
// each base sits one word below the image, since a file write
// bumps the pointer before its strobe
// 256k OS image at byte address e00000
`define DIO_IDX0_BASE 23'h6fffff
// 192k OS image at byte address fc0000
`define DIO_IDX1_BASE 23'h7dffff
// cartridge image at byte address fa0000
`define DIO_IDX2_BASE 23'h7cffff
// index 3 clears memory from word zero up
`define DIO_IDX3_BASE 23'h000000

// ********************
// serial framing
// ********************

// byte counter in the serial domain, saturates at 15
// a read word is sampled on each high byte and held through the low byte
`define DIO_BYTE_CNT_W 4

`endif

//--- design/data_io_pkg.sv
`default_nettype none

`include "data_io_defines.svh"

package data_io_pkg;

	// ********************
	// opcodes
	// ********************

	// first byte of every frame
	typedef enum logic [7:0] {
		CMD_WRITE_MEMORY = 8'h02,
		CMD_READ_MEMORY  = 8'h03,
		CMD_SET_CONTROL  = 8'h04,
		// status only, payload bytes carry no meaning
		CMD_GET_DMASTATE = 8'h05,
		CMD_ACK_DMA      = 8'h06,
		CMD_SET_VADJ     = 8'h09,
		// acts on the opcode byte alone
		CMD_NAK_DMA      = 8'h0a,
		CMD_FILE_TX      = 8'h53,
		CMD_FILE_TX_DAT  = 8'h54,
		CMD_FILE_INDEX   = 8'h55
	} spi_cmd_e;

	// decoder phases within one frame
	typedef enum logic [1:0] {
		DEC_CMD     = 2'd0,
		DEC_PAYLOAD = 2'd1,
		DEC_IGNORE  = 2'd2
	} dec_state_e;

	// ********************
	// bundles
	// ********************

	// one received byte in the sck domain
	// both flags are single-cycle pulses
	typedef struct packed {
		logic       byte_stb;
		logic       frame_end;
		logic [7:0] data;
	} rx_event_t;

	// one write request toward the memory
	// exactly one strobe at a time, never both
	typedef struct packed {
		logic [`DIO_ADDR_W-1:0] addr;
		logic [15:0]            data;
		logic                   stb_host;
		logic                   stb_file;
	} mem_wr_t;

endpackage

`default_nettype wire

//--- design/data_io_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "data_io_defines.svh"

module data_io_top
	import data_io_pkg::*;
(
	input  wire logic                       sck,
	input  wire logic                       ss,
	// serial link from the host controller
	input  wire logic                       spi_clk,
	input  wire logic                       spi_cs,
	input  wire logic                       spi_mosi,
	output logic                            spi_miso,
	// read path
	input  wire logic [15:0]                data_out_word,
	output logic                            data_out_strobe,
	// dma status path
	input  wire logic [7:0]                 status_in,
	output logic [`DIO_BYTE_CNT_W-1:0]      status_index,
	// write path and settings
	output mem_wr_t                         mem_wr,
	output logic                            data_download,
	output logic [31:0]                     ctrl_out,
	output logic [15:0]                     video_adj,
	output logic                            dma_ack,
	output logic [7:0]                      dma_status,
	output logic                            dma_nak
);

	// serial domain to sck crossing
	logic [7:0] rx_byte;
	logic       rx_toggle;
	logic       frame_idle;
	rx_event_t  rx_ev;

	spi_shifter u_shifter (
		.spi_clk       (spi_clk),
		.spi_cs        (spi_cs),
		.spi_mosi      (spi_mosi),
		.data_out_word (data_out_word),
		.status_in     (status_in),
		.spi_miso      (spi_miso),
		.rx_byte       (rx_byte),
		.rx_toggle     (rx_toggle),
		.frame_idle    (frame_idle),
		.status_index  (status_index)
	);

	byte_sync u_sync (
		.sck        (sck),
		.ss         (ss),
		.rx_toggle  (rx_toggle),
		.frame_idle (frame_idle),
		.rx_byte    (rx_byte),
		.rx_ev      (rx_ev)
	);

	cmd_decoder u_decoder (
		.sck             (sck),
		.ss              (ss),
		.rx_ev           (rx_ev),
		.mem_wr          (mem_wr),
		.data_out_strobe (data_out_strobe),
		.data_download   (data_download),
		.ctrl_out        (ctrl_out),
		.video_adj       (video_adj),
		.dma_ack         (dma_ack),
		.dma_status      (dma_status),
		.dma_nak         (dma_nak)
	);

endmodule

`default_nettype wire

//--- design/spi_shifter.sv
`default_nettype none
`timescale 1ns/10ps

`include "data_io_defines.svh"

module spi_shifter
	import data_io_pkg::*;
(
	input  wire logic                       spi_clk,
	input  wire logic                       spi_cs,
	input  wire logic                       spi_mosi,
	input  wire logic [15:0]                data_out_word,
	input  wire logic [7:0]                 status_in,
	output logic                            spi_miso,
	output logic [7:0]                      rx_byte,
	output logic                            rx_toggle,
	output logic                            frame_idle,
	output logic [`DIO_BYTE_CNT_W-1:0]      status_index
);

	// ********************
	// frame counters
	// ********************

	logic [2:0]                 bit_cnt;
	logic [`DIO_BYTE_CNT_W-1:0] byte_cnt;
	spi_cmd_e                   cmd;
	// high when the current byte is the high half of a read word
	logic                       odd;

	// shift register for the first seven bits of a byte
	logic [6:0]  sbuf;
	// copies taken on bit 0 of a byte
	logic [15:0] word_r;
	logic [7:0]  status_r;

	// free-running byte toggle, keeps its phase across frames
	logic rx_toggle_r = 1'b0;

	// bit select for the reply, MSB first
	logic [2:0] bit_sel;
	logic [3:0] word_sel;

	assign bit_sel  = ~bit_cnt;
	assign word_sel = {odd, bit_sel};

	// byte 1 is the first status byte after the opcode
	assign status_index = byte_cnt - 1'b1;
	assign rx_toggle    = rx_toggle_r;

	// chip select high holds the whole serial side idle
	always_ff @(posedge spi_clk or posedge spi_cs) begin
		if (spi_cs) begin
			bit_cnt    <= 3'd0;
			byte_cnt   <= '0;
			cmd        <= spi_cmd_e'(8'h00);
			odd        <= 1'b0;
			frame_idle <= 1'b1;
		end else begin
			frame_idle <= 1'b0;
			bit_cnt    <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				odd <= ~odd;
				// saturate so long transfers stay on the last index
				if (~&byte_cnt) begin
					byte_cnt <= byte_cnt + 1'b1;
				end
				// opcode is byte 0
				if (byte_cnt == '0) begin
					cmd <= spi_cmd_e'({sbuf, spi_mosi});
				end
			end
		end
	end

	// ********************
	// byte assembly
	// ********************

	always_ff @(posedge spi_clk) begin
		if (bit_cnt == 3'd0) begin
			status_r <= status_in;
			// read word only moves at the start of a high byte
			if (odd) begin
				word_r <= data_out_word;
			end
		end
		if (bit_cnt == 3'd7) begin
			rx_byte <= {sbuf, spi_mosi};
		end else begin
			sbuf <= {sbuf[5:0], spi_mosi};
		end
	end

	// one flip per completed byte
	always_ff @(posedge spi_clk) begin
		if (bit_cnt == 3'd7) begin
			rx_toggle_r <= ~rx_toggle_r;
		end
	end

	// ********************
	// reply shifting
	// ********************

	// mode 0, the next bit goes out on the falling edge
	// bit 0 of a byte is driven before its copy exists, so it comes from the
	// live input and the rest from the copy
	// a low byte reads only the copy, the memory may already have moved on
	always_ff @(negedge spi_clk or posedge spi_cs) begin
		if (spi_cs) begin
			spi_miso <= 1'b1;
		end else if (cmd == CMD_READ_MEMORY) begin
			if (bit_cnt == 3'd0 && odd) begin
				spi_miso <= data_out_word[word_sel];
			end else begin
				spi_miso <= word_r[word_sel];
			end
		end else begin
			// every other opcode answers with the dma status
			if (bit_cnt == 3'd0) begin
				spi_miso <= status_in[bit_sel];
			end else begin
				spi_miso <= status_r[bit_sel];
			end
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the data_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
	-f data_io.f --top-module tb_data_io -o sim_data_io

out=$(./obj_dir/sim_data_io)
echo "$out"

if echo "$out" | grep -q -F '*** TEST PASSED ***'; then
	exit 0
else
	exit 1
fi

//--- tb/tb_spi_tasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// ********************
// serial link driver
// ********************

// half of an 800 ns bit, inputs move 10 ns after a rising sck edge
task automatic wait_half_bit();
	repeat (4) @(posedge sck);
	#10;
endtask

// mode 0, MSB first
// reply bit is read just before the rising edge that would change it
task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
	int b;
	rx = 8'h00;
	for (b = 7; b >= 0; b--) begin
		spi_mosi = tx[b];
		wait_half_bit();
		rx = {rx[6:0], spi_miso};
		spi_clk = 1'b1;
		wait_half_bit();
		spi_clk = 1'b0;
	end
endtask

// n bytes out of tx_buf, replies into rx_buf
task automatic run_frame(input int n);
	int i;
	wait_half_bit();
	spi_cs = 1'b0;
	for (i = 0; i < n; i++) begin
		// status index of this byte, settled since the last rising edge
		idx_buf[i] = status_index;
		shift_byte(tx_buf[i], rx_buf[i]);
	end
	wait_half_bit();
	spi_cs = 1'b1;
	spi_mosi = 1'b0;
	// frame_end arrives 3 to 4 cycles after cs, effects one later
	repeat (8) @(posedge sck);
	#10;
endtask

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic [7:0] next_lfsr_byte();
	logic [7:0] b;
	logic       fb;
	int         i;
	b = 8'h00;
	for (i = 0; i < 8; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		b = {b[6:0], fb};
	end
	return b;
endfunction

`endif

//--- tb/tb_data_io.sv
`default_nettype none
`timescale 1ns/10ps

`include "data_io_defines.svh"

module tb_data_io
	import data_io_pkg::*;
();

	// what a table row checks
	typedef enum logic [3:0] {
		K_CTRL, K_VADJ, K_INDEX, K_FTX, K_FDAT,
		K_HOST, K_READ, K_STAT, K_ACK, K_NAK, K_UNK
	} kind_e;

	// opcode, payload length, check kind, fixed payload or index
	typedef struct packed {
		logic [7:0] op;
		logic [3:0] len;
		kind_e      kind;
		logic [7:0] val;
	} row_t;

	localparam int num_rows = 22;

	// ********************
	// test table
	// ********************

	localparam row_t test_table [0:num_rows-1] = '{
		{8'h04, 4'd4, K_CTRL, 8'h00},
		{8'h09, 4'd2, K_VADJ, 8'h00},
		// one file write behind each index
		{8'h55, 4'd1, K_INDEX, 8'h00},
		{8'h53, 4'd1, K_FTX, 8'h01},
		{8'h54, 4'd6, K_FDAT, 8'h00},
		{8'h55, 4'd1, K_INDEX, 8'h01},
		{8'h54, 4'd4, K_FDAT, 8'h00},
		{8'h55, 4'd1, K_INDEX, 8'h02},
		{8'h54, 4'd8, K_FDAT, 8'h00},
		{8'h55, 4'd1, K_INDEX, 8'h03},
		{8'h54, 4'd2, K_FDAT, 8'h00},
		// out of range, pointer stays
		{8'h55, 4'd1, K_INDEX, 8'h07},
		{8'h54, 4'd4, K_FDAT, 8'h00},
		{8'h53, 4'd1, K_FTX, 8'h00},
		// odd length drops the last byte
		{8'h02, 4'd5, K_HOST, 8'h00},
		{8'h02, 4'd4, K_HOST, 8'h00},
		{8'h03, 4'd6, K_READ, 8'h00},
		{8'h05, 4'd3, K_STAT, 8'h00},
		{8'h06, 4'd1, K_ACK, 8'h00},
		{8'h0a, 4'd0, K_NAK, 8'h00},
		{8'h7e, 4'd4, K_UNK, 8'h00},
		{8'h09, 4'd2, K_VADJ, 8'h00}
	};

	logic                       sck;
	logic                       ss;
	logic                       spi_clk;
	logic                       spi_cs;
	logic                       spi_mosi;
	logic                       spi_miso;
	logic [15:0]                data_out_word;
	logic                       data_out_strobe;
	logic [7:0]                 status_in;
	logic [`DIO_BYTE_CNT_W-1:0] status_index;
	mem_wr_t                    mem_wr;
	logic                       data_download;
	logic [31:0]                ctrl_out;
	logic [15:0]                video_adj;
	logic                       dma_ack;
	logic [7:0]                 dma_status;
	logic                       dma_nak;

	logic [31:0] lfsr_state = 32'hd5feeed7;
	logic [7:0]  tx_buf [0:8];
	logic [7:0]  rx_buf [0:8];
	// status index seen during each byte of a frame
	logic [`DIO_BYTE_CNT_W-1:0] idx_buf [0:8];
	// memory model word index, moves on data_out_strobe
	logic [15:0] rd_idx = 16'd0;
	mem_wr_t     wr_log [$];
	// host, file, read strobe, ack, nak
	int          pulse_cnt [0:4] = '{0, 0, 0, 0, 0};
	string       pulse_name [0:4] = '{"stb_host", "stb_file", "data_out_strobe",
		"dma_ack", "dma_nak"};
	int          err_total = 0;
	int          tests_failed = 0;

	`include "tb_spi_tasks.svh"

	data_io_top DUT (.*);

	// fill pattern over the whole word index
	function automatic logic [15:0] model_word(input logic [15:0] idx);
		return (idx * 16'h9e37) ^ {idx[7:0], idx[15:8]} ^ 16'h5a3c;
	endfunction

	function automatic logic [`DIO_ADDR_W-1:0] base_address(input logic [7:0] k);
		case (k)
		8'd0:    return `DIO_IDX0_BASE;
		8'd1:    return `DIO_IDX1_BASE;
		8'd2:    return `DIO_IDX2_BASE;
		default: return `DIO_IDX3_BASE;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %0h, expected %0h", name, got, exp);
			err_total++;
		end
	endtask

	initial begin
		sck = 1'b0;
		forever #50 sck = ~sck;
	end

	// longest row takes well under 80 us
	initial begin
		#(num_rows * 80_000);
		$display("timeout, the test table did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	assign data_out_word = model_word(rd_idx);

	// ********************
	// monitor
	// ********************

	// outputs are steady at the falling sck edge
	always @(negedge sck) begin
		logic [4:0] pulses;
		int         j;
		pulses = {dma_nak, dma_ack, data_out_strobe, mem_wr.stb_file, mem_wr.stb_host};
		if (mem_wr.stb_host || mem_wr.stb_file) begin
			wr_log.push_back(mem_wr);
		end
		for (j = 0; j < 5; j++) begin
			if (pulses[j]) begin
				pulse_cnt[j]++;
			end
		end
		if (data_out_strobe) begin
			rd_idx <= rd_idx + 16'd1;
		end
	end

	initial begin
		row_t                   row;
		logic [`DIO_ADDR_W-1:0] ptr;
		logic [31:0]            exp_ctrl;
		logic [15:0]            exp_vadj;
		logic [15:0]            exp_word;
		logic [7:0]             exp_dst;
		logic                   exp_dl;
		int                     base_cnt [0:4];
		int                     exp_cnt [0:4];
		logic [15:0]            rd0;
		int                     wr0;
		int                     err0;
		int                     r;
		int                     k;

		ss = 1'b1;
		spi_clk = 1'b0;
		// chip select rises shortly after start and clears the serial side
		spi_cs = 1'b0;
		spi_mosi = 1'b0;
		status_in = 8'h00;
		#10;
		spi_cs = 1'b1;
		repeat (5) @(posedge sck);
		#10;
		ss = 1'b0;
		@(posedge sck);
		#10;
		compare_value("spi_miso", spi_miso, 1);
		compare_value("ctrl_out", ctrl_out, 0);
		compare_value("video_adj", video_adj, 0);
		compare_value("mem_wr", mem_wr, 0);
		compare_value("data_download", data_download, 0);
		compare_value("dma_status", dma_status, 0);
		compare_value("data_out_strobe", data_out_strobe, 0);
		compare_value("dma_ack", dma_ack, 0);
		compare_value("dma_nak", dma_nak, 0);
		$display("reset values %s", (err_total == 0) ? "ok" : "bad");
		ptr = '0;
		// settings model, moves only with the rows that set it
		exp_ctrl = 32'h0000_0000;
		exp_vadj = 16'h0000;
		exp_dl = 1'b0;
		exp_dst = 8'h00;

		for (r = 0; r < num_rows; r++) begin
			row = test_table[r];
			err0 = err_total;
			status_in = next_lfsr_byte();
			tx_buf[0] = row.op;
			for (k = 0; k < row.len; k++) begin
				tx_buf[k + 1] = next_lfsr_byte();
			end
			if (row.kind == K_INDEX || row.kind == K_FTX) begin
				tx_buf[1] = row.val;
			end
			// pulses counted from here
			for (k = 0; k < 5; k++) begin
				base_cnt[k] = pulse_cnt[k];
				exp_cnt[k] = 0;
			end
			wr0 = wr_log.size();
			rd0 = rd_idx;

			run_frame(row.len + 1);

			case (row.kind)
			K_CTRL: exp_ctrl = {tx_buf[1], tx_buf[2], tx_buf[3], tx_buf[4]};
			K_VADJ: exp_vadj = {tx_buf[1], tx_buf[2]};
			K_INDEX: begin
				if (row.val < 4) begin
					ptr = base_address(row.val);
				end
			end
			K_FTX: exp_dl = (tx_buf[1] != 8'h00);
			// file words land one above the pointer, host words on it
			K_FDAT, K_HOST: begin
				exp_cnt[(row.kind == K_FDAT) ? 1 : 0] = row.len / 2;
				for (k = 0; k < row.len / 2 && wr0 + k < wr_log.size(); k++) begin
					compare_value("mem_wr.addr", wr_log[wr0 + k].addr,
						(row.kind == K_FDAT) ? ptr + k + 1 : ptr);
					compare_value("mem_wr.data", wr_log[wr0 + k].data,
						{tx_buf[2 * k + 1], tx_buf[2 * k + 2]});
				end
				if (row.kind == K_FDAT) begin
					ptr = ptr + row.len / 2;
				end
			end
			K_READ: begin
				exp_cnt[2] = row.len / 2;
				for (k = 0; k < row.len; k++) begin
					exp_word = model_word(rd0 + k / 2);
					compare_value("spi_miso", rx_buf[k + 1],
						(k % 2 == 0) ? exp_word[15:8] : exp_word[7:0]);
				end
			end
			// first byte after the opcode is status index 0
			K_STAT: begin
				for (k = 0; k < row.len; k++) begin
					compare_value("spi_miso", rx_buf[k + 1], status_in);
					compare_value("status_index", idx_buf[k + 1], k);
				end
			end
			K_ACK: begin
				exp_cnt[3] = 1;
				exp_dst = tx_buf[1];
			end
			K_NAK: exp_cnt[4] = 1;
			default: begin
			end
			endcase

			compare_value("ctrl_out", ctrl_out, exp_ctrl);
			compare_value("video_adj", video_adj, exp_vadj);
			compare_value("data_download", data_download, exp_dl);
			compare_value("dma_status", dma_status, exp_dst);
			for (k = 0; k < 5; k++) begin
				compare_value({pulse_name[k], " pulses"}, pulse_cnt[k] - base_cnt[k], exp_cnt[k]);
			end
			if (err_total != err0) begin
				tests_failed++;
			end
			$display("row %0d opcode %02h %s", r, row.op, (err_total == err0) ? "ok" : "bad");
		end

		$display("%0d rows, %0d bad, %0d check errors", num_rows, tests_failed, err_total);
		if (err_total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
